// ==== flist.f ====
src/ooo_pkg.sv
src/inst_decoder.sv
src/dispatch_scheduler.sv
src/register_alias_table.sv
src/reorder_buffer.sv
src/reservation_stations.sv
src/alu_unit.sv
src/ooo_core_top.sv
tests/ooo_core_checker.sv
tests/tb_ooo_core.sv

// ==== src/alu_unit.sv ====
module alu_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_valid,
  input  ooo_pkg::rs_entry_t issue,
  output ooo_pkg::cdb_t      cdb
);

  ooo_pkg::word_t a;
  ooo_pkg::word_t b;
  ooo_pkg::word_t result;

  assign a = issue.value_1;
  assign b = issue.value_2;

  always_comb begin
    case (issue.alu_op)
      ooo_pkg::ALU_ADD:    result = a + b;
      ooo_pkg::ALU_SUB:    result = a - b;
      ooo_pkg::ALU_AND:    result = a & b;
      ooo_pkg::ALU_OR:     result = a | b;
      ooo_pkg::ALU_XOR:    result = a ^ b;
      // Signed compare, result is 0 or 1
      ooo_pkg::ALU_SLT:    result = {{(ooo_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ooo_pkg::ALU_PASS_B: result = b;
      default:             result = '0;
    endcase
  end

  // Broadcast one cycle after issue
  always_ff @(posedge clk) begin
    if (rst) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= issue_valid;
    end
    cdb.tag   <= issue.tag;
    cdb.value <= result;
  end

endmodule

// ==== src/dispatch_scheduler.sv ====
module dispatch_scheduler (
  input  logic                                         clk,
  input  logic                                         rst,
  input  ooo_pkg::dispatch_t                           dec,
  input  logic                                         inst_valid,
  input  ooo_pkg::map_entry_t [ooo_pkg::NUM_REGS-1:0]  map,
  input  ooo_pkg::rob_entry_t [ooo_pkg::ROB_SIZE-1:0]  rob_entries,
  input  ooo_pkg::rob_idx_t                            rob_tail,
  input  logic                                         rob_full,
  input  logic                                         rs_free,
  input  ooo_pkg::cdb_t                                cdb,
  input  ooo_pkg::victim_t                             victim,
  output logic                                         inst_ready,
  output logic                                         alloc,
  output ooo_pkg::rob_entry_t                          new_rob,
  output ooo_pkg::rs_entry_t                           new_rs,
  output logic                                         bypass_rs,
  output logic                                         map_we,
  output ooo_pkg::tag_t                                map_tag
);

  ooo_pkg::map_entry_t op_1;
  ooo_pkg::map_entry_t op_2;
  ooo_pkg::tag_t       new_tag;

  // Resolve one source to a value or a pending tag
  // Result tag of zero means the value is usable now
  function automatic ooo_pkg::map_entry_t resolve(input ooo_pkg::reg_idx_t src);
    ooo_pkg::map_entry_t ent;
    ooo_pkg::map_entry_t res;
    ooo_pkg::rob_idx_t   idx;
    ent = map[src];
    res = '0;
    idx = ooo_pkg::rob_idx_t'(ent.tag - 1'b1);
    if (src == '0) begin
      // x0 is hardwired
      res = '0;
    end else if (ent.tag != '0 && cdb.valid && cdb.tag == ent.tag) begin
      res.value = cdb.value;
    end else if (ent.tag != '0 && victim.valid && victim.rd == src &&
                 victim.tag == ent.tag) begin
      // Producer retires this very cycle
      res.value = victim.value;
    end else if (ent.tag != '0 && rob_entries[idx].ready) begin
      res.value = rob_entries[idx].value;
    end else if (ent.tag == '0) begin
      res.value = ent.value;
    end else begin
      res.tag = ent.tag;
    end
    return res;
  endfunction

  assign new_tag = ooo_pkg::tag_t'(rob_tail) + 1'b1;

  always_comb begin
    op_1 = resolve(dec.rs1);
    op_2 = resolve(dec.rs2);
    // Immediate forms take operand 2 from the decoder
    if (dec.ctrl.alusrc) begin
      op_2.value = dec.imm;
      op_2.tag   = '0;
    end
  end

  // ECALL and unsupported never reach an ALU
  assign bypass_rs = dec.ctrl.ecall || dec.ctrl.unsupported;

  always_comb begin
    new_rob       = '0;
    new_rob.busy  = 1'b1;
    new_rob.ready = bypass_rs;
    new_rob.pc    = dec.pc;
    new_rob.rd    = dec.rd;
    new_rob.ctrl  = dec.ctrl;
  end

  always_comb begin
    new_rs.busy    = 1'b1;
    new_rs.alu_op  = dec.ctrl.alu_op;
    new_rs.tag     = new_tag;
    new_rs.value_1 = op_1.value;
    new_rs.tag_1   = op_1.tag;
    new_rs.value_2 = op_2.value;
    new_rs.tag_2   = op_2.tag;
  end

  // Need a ROB slot always, a station only for ALU work
  assign inst_ready = !rob_full && (bypass_rs || rs_free);
  assign alloc      = inst_valid && inst_ready;

  // x0 and non-writing instructions leave the map alone
  assign map_we  = alloc && dec.ctrl.regwrite && (dec.rd != '0);
  assign map_tag = new_tag;

  // Tail slot is empty whenever an instruction allocates
  a_alloc_slot_free: assert property (
    @(posedge clk) disable iff (rst) alloc |-> !rob_entries[rob_tail].busy
  );

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder (
  input  ooo_pkg::word_t     inst,
  input  ooo_pkg::word_t     pc,
  output ooo_pkg::dispatch_t dec
);

  ooo_pkg::opcode_e    opcode;
  ooo_pkg::ctrl_bits_t ctrl;
  ooo_pkg::word_t      imm;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign opcode = ooo_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = ooo_pkg::ALU_ADD;
    // I-type immediate unless LUI overrides it
    imm = {{20{inst[31]}}, inst[31:20]};
    case (opcode)
      ooo_pkg::OPC_OP: begin
        ctrl.regwrite = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = ooo_pkg::ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ooo_pkg::ALU_SUB;
          10'b0000000_111: ctrl.alu_op = ooo_pkg::ALU_AND;
          10'b0000000_110: ctrl.alu_op = ooo_pkg::ALU_OR;
          10'b0000000_100: ctrl.alu_op = ooo_pkg::ALU_XOR;
          10'b0000000_010: ctrl.alu_op = ooo_pkg::ALU_SLT;
          default: ctrl.unsupported = 1'b1;
        endcase
      end
      ooo_pkg::OPC_OP_IMM: begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        // Only ADDI, ANDI, ORI and XORI are in the subset
        case (funct3)
          3'b000: ctrl.alu_op = ooo_pkg::ALU_ADD;
          3'b111: ctrl.alu_op = ooo_pkg::ALU_AND;
          3'b110: ctrl.alu_op = ooo_pkg::ALU_OR;
          3'b100: ctrl.alu_op = ooo_pkg::ALU_XOR;
          default: ctrl.unsupported = 1'b1;
        endcase
      end
      ooo_pkg::OPC_LUI: begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.alu_op   = ooo_pkg::ALU_PASS_B;
        imm = {inst[31:12], 12'b0};
      end
      ooo_pkg::OPC_SYSTEM: begin
        // Plain ECALL has every other bit clear
        if (inst[31:7] == '0) begin
          ctrl.ecall = 1'b1;
        end else begin
          ctrl.unsupported = 1'b1;
        end
      end
      default: ctrl.unsupported = 1'b1;
    endcase
    // A failed sub-decode must not write
    if (ctrl.unsupported) begin
      ctrl.regwrite = 1'b0;
    end
  end

  always_comb begin
    dec.pc   = pc;
    dec.ctrl = ctrl;
    dec.imm  = imm;
    // No destination unless the instruction writes
    dec.rd   = ctrl.regwrite ? inst[11:7] : '0;
    // LUI has no rs1, immediates have no rs2
    dec.rs1  = (opcode == ooo_pkg::OPC_LUI) ? '0 : inst[19:15];
    dec.rs2  = ctrl.alusrc ? '0 : inst[24:20];
  end

endmodule

// ==== src/ooo_core_top.sv ====
module ooo_core_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             inst_valid,
  input  ooo_pkg::word_t   inst,
  input  ooo_pkg::word_t   pc,
  output logic             inst_ready,
  output logic             commit_valid,
  output ooo_pkg::commit_t commit
);

  ooo_pkg::dispatch_t                          dec;
  ooo_pkg::map_entry_t [ooo_pkg::NUM_REGS-1:0] map;
  ooo_pkg::rob_entry_t [ooo_pkg::ROB_SIZE-1:0] rob_entries;
  ooo_pkg::rob_idx_t                           rob_tail;
  logic                                        rob_full;
  logic                                        rs_free;
  ooo_pkg::cdb_t                               cdb;
  ooo_pkg::victim_t                            victim;
  logic                                        alloc;
  ooo_pkg::rob_entry_t                         new_rob;
  ooo_pkg::rs_entry_t                          new_rs;
  logic                                        bypass_rs;
  logic                                        map_we;
  ooo_pkg::tag_t                               map_tag;
  logic                                        issue_valid;
  ooo_pkg::rs_entry_t                          issue;

  inst_decoder i_decoder (.inst(inst), .pc(pc), .dec(dec));

  dispatch_scheduler i_scheduler (
    .clk(clk), .rst(rst), .dec(dec), .inst_valid(inst_valid), .map(map),
    .rob_entries(rob_entries), .rob_tail(rob_tail), .rob_full(rob_full),
    .rs_free(rs_free), .cdb(cdb), .victim(victim), .inst_ready(inst_ready),
    .alloc(alloc), .new_rob(new_rob), .new_rs(new_rs), .bypass_rs(bypass_rs),
    .map_we(map_we), .map_tag(map_tag)
  );

  register_alias_table i_rat (
    .clk(clk), .rst(rst), .map_we(map_we), .map_rd(dec.rd), .map_tag(map_tag),
    .victim(victim), .map(map)
  );

  reorder_buffer i_rob (
    .clk(clk), .rst(rst), .alloc(alloc), .new_rob(new_rob), .cdb(cdb),
    .rob_entries(rob_entries), .rob_tail(rob_tail), .rob_full(rob_full),
    .victim(victim), .commit_valid(commit_valid), .commit(commit)
  );

  // Stations fill only for ALU work
  reservation_stations i_rs (
    .clk(clk), .rst(rst), .write(alloc && !bypass_rs), .new_rs(new_rs), .cdb(cdb),
    .rs_free(rs_free), .issue_valid(issue_valid), .issue(issue)
  );

  alu_unit i_alu (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue), .cdb(cdb)
  );

endmodule

// ==== src/ooo_pkg.sv ====
package ooo_pkg;

  // Core sizes
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int ROB_SIZE = 8;
  localparam int RS_SIZE  = 4;

  typedef logic [XLEN-1:0]               word_t;
  typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;
  typedef logic [$clog2(ROB_SIZE)-1:0]   rob_idx_t;
  // Tag is ROB index plus one, zero means the value is present
  typedef logic [$clog2(ROB_SIZE):0]     tag_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // RV32I major opcodes known to the decoder
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alusrc;
    logic    regwrite;
    logic    ecall;
    logic    unsupported;
  } ctrl_bits_t;

  typedef struct packed {
    word_t      pc;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    ctrl_bits_t ctrl;
  } dispatch_t;

  typedef struct packed {
    tag_t  tag;
    word_t value;
  } map_entry_t;

  typedef struct packed {
    logic       busy;
    logic       ready;
    word_t      pc;
    reg_idx_t   rd;
    word_t      value;
    ctrl_bits_t ctrl;
  } rob_entry_t;

  typedef struct packed {
    logic    busy;
    alu_op_e alu_op;
    tag_t    tag;
    word_t   value_1;
    tag_t    tag_1;
    word_t   value_2;
    tag_t    tag_2;
  } rs_entry_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
  } cdb_t;

  // Instruction retiring from the ROB head this cycle
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    tag_t     tag;
    word_t    value;
  } victim_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    value;
    logic     regwrite;
    logic     unsupported;
  } commit_t;

endpackage

// ==== src/register_alias_table.sv ====
module register_alias_table (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        map_we,
  input  ooo_pkg::reg_idx_t                           map_rd,
  input  ooo_pkg::tag_t                               map_tag,
  input  ooo_pkg::victim_t                            victim,
  output ooo_pkg::map_entry_t [ooo_pkg::NUM_REGS-1:0] map
);

  always_ff @(posedge clk) begin
    if (rst) begin
      map <= '0;
    end else begin
      // Retirement updates the architectural value
      if (victim.valid && victim.rd != '0) begin
        map[victim.rd].value <= victim.value;
        // Keep a newer rename alive
        if (map[victim.rd].tag == victim.tag) begin
          map[victim.rd].tag <= '0;
        end
      end
      // Fresh rename wins over a same-cycle clear
      if (map_we && map_rd != '0) begin
        map[map_rd].tag <= map_tag;
      end
    end
  end

endmodule

// ==== src/reorder_buffer.sv ====
module reorder_buffer (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        alloc,
  input  ooo_pkg::rob_entry_t                         new_rob,
  input  ooo_pkg::cdb_t                               cdb,
  output ooo_pkg::rob_entry_t [ooo_pkg::ROB_SIZE-1:0] rob_entries,
  output ooo_pkg::rob_idx_t                           rob_tail,
  output logic                                        rob_full,
  output ooo_pkg::victim_t                            victim,
  output logic                                        commit_valid,
  output ooo_pkg::commit_t                            commit
);

  ooo_pkg::rob_idx_t                head;
  logic [$clog2(ooo_pkg::ROB_SIZE):0] count;
  ooo_pkg::rob_idx_t                cdb_idx;
  ooo_pkg::rob_entry_t              head_ent;
  logic                             retire;

  assign cdb_idx  = ooo_pkg::rob_idx_t'(cdb.tag - 1'b1);
  assign head_ent = rob_entries[head];
  // Oldest entry leaves as soon as it has a result
  assign retire   = head_ent.busy && head_ent.ready;
  assign rob_full = (count == ooo_pkg::ROB_SIZE);

  always_ff @(posedge clk) begin
    if (rst) begin
      head     <= '0;
      rob_tail <= '0;
      count    <= '0;
      for (int i = 0; i < ooo_pkg::ROB_SIZE; i++) begin
        rob_entries[i].busy  <= 1'b0;
        rob_entries[i].ready <= 1'b0;
      end
    end else begin
      // Result capture from the bus
      if (cdb.valid) begin
        rob_entries[cdb_idx].value <= cdb.value;
        rob_entries[cdb_idx].ready <= 1'b1;
      end
      if (retire) begin
        rob_entries[head].busy <= 1'b0;
        head <= head + 1'b1;
      end
      if (alloc) begin
        rob_entries[rob_tail] <= new_rob;
        rob_tail <= rob_tail + 1'b1;
      end
      if (alloc && !retire) begin
        count <= count + 1'b1;
      end else if (!alloc && retire) begin
        count <= count - 1'b1;
      end
    end
  end

  // Only register writers update the map
  always_comb begin
    victim.valid = retire && head_ent.ctrl.regwrite && (head_ent.rd != '0);
    victim.rd    = head_ent.rd;
    victim.tag   = ooo_pkg::tag_t'(head) + 1'b1;
    victim.value = head_ent.value;
  end

  assign commit_valid = retire;

  always_comb begin
    commit.pc          = head_ent.pc;
    commit.rd          = head_ent.rd;
    commit.value       = head_ent.value;
    commit.regwrite    = head_ent.ctrl.regwrite;
    commit.unsupported = head_ent.ctrl.unsupported || head_ent.ctrl.ecall;
  end

  a_cdb_hits_busy: assert property (
    @(posedge clk) disable iff (rst) cdb.valid |-> rob_entries[cdb_idx].busy
  );

  a_count_bound: assert property (
    @(posedge clk) disable iff (rst) count <= ooo_pkg::ROB_SIZE
  );

endmodule

// ==== src/reservation_stations.sv ====
module reservation_stations (
  input  logic               clk,
  input  logic               rst,
  input  logic               write,
  input  ooo_pkg::rs_entry_t new_rs,
  input  ooo_pkg::cdb_t      cdb,
  output logic               rs_free,
  output logic               issue_valid,
  output ooo_pkg::rs_entry_t issue
);

  ooo_pkg::rs_entry_t [ooo_pkg::RS_SIZE-1:0] slots;
  ooo_pkg::rs_entry_t [ooo_pkg::RS_SIZE-1:0] woken;
  logic [$clog2(ooo_pkg::RS_SIZE)-1:0]       free_idx;
  logic [$clog2(ooo_pkg::RS_SIZE)-1:0]       issue_idx;

  // Bus capture applied before issue selection
  always_comb begin
    woken = slots;
    for (int i = 0; i < ooo_pkg::RS_SIZE; i++) begin
      if (cdb.valid && slots[i].tag_1 != '0 && slots[i].tag_1 == cdb.tag) begin
        woken[i].value_1 = cdb.value;
        woken[i].tag_1   = '0;
      end
      if (cdb.valid && slots[i].tag_2 != '0 && slots[i].tag_2 == cdb.tag) begin
        woken[i].value_2 = cdb.value;
        woken[i].tag_2   = '0;
      end
    end
  end

  // Scan downward so the lowest index wins
  always_comb begin
    rs_free     = 1'b0;
    free_idx    = '0;
    issue_valid = 1'b0;
    issue_idx   = '0;
    for (int i = ooo_pkg::RS_SIZE - 1; i >= 0; i--) begin
      if (!slots[i].busy) begin
        rs_free  = 1'b1;
        free_idx = i[$clog2(ooo_pkg::RS_SIZE)-1:0];
      end
      if (woken[i].busy && woken[i].tag_1 == '0 && woken[i].tag_2 == '0) begin
        issue_valid = 1'b1;
        issue_idx   = i[$clog2(ooo_pkg::RS_SIZE)-1:0];
      end
    end
  end

  assign issue = woken[issue_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ooo_pkg::RS_SIZE; i++) begin
        slots[i].busy <= 1'b0;
      end
    end else begin
      slots <= woken;
      // Issued slot opens for the next dispatch
      if (issue_valid) begin
        slots[issue_idx].busy <= 1'b0;
      end
      if (write) begin
        slots[free_idx] <= new_rs;
      end
    end
  end

  a_write_needs_slot: assert property (
    @(posedge clk) disable iff (rst) write |-> rs_free
  );

endmodule

// ==== tests/ooo_core_checker.sv ====
module ooo_core_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic             inst_valid,
  input  logic             inst_ready,
  input  logic             commit_valid,
  input  ooo_pkg::commit_t commit,
  output int               mismatches,
  output int               other_errors,
  output int               pending
);

  // Expected commit records in program order
  ooo_pkg::commit_t exp_q[$];
  int               accepted;
  logic             ready_checked;

  initial begin
    mismatches    = 0;
    other_errors  = 0;
    pending       = 0;
    accepted      = 0;
    ready_checked = 1'b0;
  end

  // Filled by the testbench once per accepted instruction
  task automatic expect_commit(input ooo_pkg::commit_t rec);
    exp_q.push_back(rec);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t: %s", $time, what);
    other_errors++;
  endtask

  // Leftover records mean lost instructions
  task automatic final_checks();
    if (exp_q.size() != 0) begin
      $display("Error: %0d accepted instructions never committed", exp_q.size());
      other_errors++;
    end
  endtask

  // Negedge sampling, DUT outputs settle well before it
  always @(negedge clk) begin : sample_commit
    ooo_pkg::commit_t exp_rec;
    if (!rst) begin
      if (accepted == 0) begin
        if (commit_valid) begin
          report_problem("commit seen before any instruction was accepted");
        end
        // First cycle out of reset
        if (!ready_checked) begin
          ready_checked = 1'b1;
          if (!inst_ready) begin
            report_problem("inst_ready is low right after reset");
          end
        end
      end
      if (inst_valid && inst_ready) begin
        accepted++;
      end
      if (commit_valid) begin
        if (exp_q.size() == 0) begin
          report_problem("commit arrived with no accepted instruction pending");
        end else begin
          exp_rec = exp_q.pop_front();
          compare_field("commit.pc", commit.pc, exp_rec.pc);
          compare_field("commit.rd", 32'(commit.rd), 32'(exp_rec.rd));
          compare_field("commit.value", commit.value, exp_rec.value);
          compare_field("commit.regwrite", 32'(commit.regwrite), 32'(exp_rec.regwrite));
          compare_field("commit.unsupported", 32'(commit.unsupported),
                        32'(exp_rec.unsupported));
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

// ==== tests/tb_ooo_core.sv ====
module tb_ooo_core;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 16;
  localparam int          NUM_ROWS     = 24;
  localparam logic [15:0] LFSR_SEED    = 16'd64780;

  // Operation kinds of the stimulus table
  typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ECALL, OP_BAD
  } op_kind_e;

  // Burst means no idle gap after this row
  typedef struct packed {
    op_kind_e       op;
    logic [4:0]     rd;
    logic [4:0]     rs1;
    logic [4:0]     rs2;
    ooo_pkg::word_t imm;
    logic           burst;
  } row_t;

  logic             clk;
  logic             rst;
  logic             inst_valid;
  ooo_pkg::word_t   inst;
  ooo_pkg::word_t   pc;
  logic             inst_ready;
  logic             commit_valid;
  ooo_pkg::commit_t commit;
  int               mismatches;
  int               other_errors;
  int               pending;

  row_t           rows [NUM_ROWS];
  int             num_rows;
  // Architectural register model
  ooo_pkg::word_t regs [32];
  logic [15:0]    lfsr;

  ooo_core_top i_dut (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .pc(pc),
    .inst_ready(inst_ready), .commit_valid(commit_valid), .commit(commit)
  );

  ooo_core_checker i_checker (
    .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_ready(inst_ready),
    .commit_valid(commit_valid), .commit(commit), .mismatches(mismatches),
    .other_errors(other_errors), .pending(pending)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic take_random_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  task automatic add_row(input op_kind_e op, input int rd, input int rs1, input int rs2,
                         input int imm, input logic burst);
    rows[num_rows].op    = op;
    rows[num_rows].rd    = rd[4:0];
    rows[num_rows].rs1   = rs1[4:0];
    rows[num_rows].rs2   = rs2[4:0];
    rows[num_rows].imm   = imm;
    rows[num_rows].burst = burst;
    num_rows++;
  endtask

  // RV32I encodings built from the row fields
  function automatic ooo_pkg::word_t encode(input row_t r);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    f3 = 3'b000;
    case (r.op)
      OP_SUB: f7 = 7'b0100000;
      OP_AND, OP_ANDI: f3 = 3'b111;
      OP_OR, OP_ORI: f3 = 3'b110;
      OP_XOR, OP_XORI: f3 = 3'b100;
      OP_SLT: f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    case (r.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT:
        return {f7, r.rs2, r.rs1, f3, r.rd, 7'b0110011};
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI:
        return {r.imm[11:0], r.rs1, f3, r.rd, 7'b0010011};
      OP_LUI: return {r.imm[19:0], r.rd, 7'b0110111};
      OP_ECALL: return 32'h0000_0073;
      // LW, a load is outside the subset
      default: return {r.imm[11:0], r.rs1, 3'b010, r.rd, 7'b0000011};
    endcase
  endfunction

  // Expected commit record in program order, updates the register model
  task automatic predict(input row_t r, input ooo_pkg::word_t row_pc,
                         output ooo_pkg::commit_t rec);
    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    ooo_pkg::word_t result;
    logic           imm_form;
    imm_form = (r.op == OP_ADDI) || (r.op == OP_ANDI) || (r.op == OP_ORI) ||
               (r.op == OP_XORI);
    a = regs[r.rs1];
    b = imm_form ? r.imm : regs[r.rs2];
    case (r.op)
      OP_ADD, OP_ADDI: result = a + b;
      OP_SUB: result = a - b;
      OP_AND, OP_ANDI: result = a & b;
      OP_OR, OP_ORI: result = a | b;
      OP_XOR, OP_XORI: result = a ^ b;
      OP_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_LUI: result = {r.imm[19:0], 12'h000};
      default: result = '0;
    endcase
    rec    = '0;
    rec.pc = row_pc;
    if (r.op == OP_ECALL || r.op == OP_BAD) begin
      // No destination and no value
      rec.unsupported = 1'b1;
    end else begin
      rec.rd       = r.rd;
      rec.value    = result;
      rec.regwrite = 1'b1;
      if (r.rd != 5'd0) begin
        regs[r.rd] = result;
      end
    end
  endtask

  // Holds the row until the handshake completes
  task automatic send_row(input int idx);
    logic             accepted;
    ooo_pkg::commit_t rec;
    inst_valid = 1'b1;
    inst       = encode(rows[idx]);
    pc         = 32'h0000_0100 + 32'(idx * 4);
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = inst_ready;
      @(posedge clk);
      #1;
    end
    predict(rows[idx], pc, rec);
    i_checker.expect_commit(rec);
  endtask

  initial begin
    logic [1:0] gap;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    lfsr       = LFSR_SEED;
    num_rows   = 0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    // Independent ALU, immediate, LUI and SLT
    add_row(OP_ADDI, 1, 0, 0, 5, 1'b0);
    add_row(OP_ADDI, 2, 0, 0, -3, 1'b0);
    add_row(OP_LUI, 3, 0, 0, 32'h12345, 1'b0);
    add_row(OP_SLT, 4, 2, 1, 0, 1'b0);
    add_row(OP_XORI, 5, 0, 0, 32'h0F0, 1'b0);
    add_row(OP_OR, 6, 5, 1, 0, 1'b0);
    // Back-to-back RAW chain
    // r7 is read again from the bus and then from the retiring producer
    add_row(OP_ADDI, 7, 1, 0, 10, 1'b1);
    add_row(OP_ADD, 8, 7, 7, 0, 1'b1);
    add_row(OP_SUB, 9, 8, 7, 0, 1'b1);
    add_row(OP_AND, 10, 9, 7, 0, 1'b0);
    // x0 writes, then a register renamed twice
    add_row(OP_ADDI, 0, 1, 0, 99, 1'b1);
    add_row(OP_ADD, 11, 0, 1, 0, 1'b1);
    add_row(OP_ADDI, 12, 0, 0, 1, 1'b1);
    add_row(OP_ADDI, 12, 12, 0, 2, 1'b1);
    add_row(OP_ORI, 13, 12, 0, 32'h100, 1'b0);
    // ECALL and an unknown opcode between ALU work
    add_row(OP_ECALL, 0, 0, 0, 0, 1'b0);
    add_row(OP_BAD, 14, 1, 0, 8, 1'b0);
    add_row(OP_ADD, 14, 13, 12, 0, 1'b1);
    // Long dependent chain with no idle gaps
    add_row(OP_ADDI, 15, 14, 0, 1, 1'b1);
    add_row(OP_ADDI, 15, 15, 0, 1, 1'b1);
    add_row(OP_XOR, 16, 15, 2, 0, 1'b1);
    add_row(OP_SLT, 17, 16, 0, 0, 1'b1);
    add_row(OP_ADDI, 15, 15, 0, -7, 1'b1);
    add_row(OP_ANDI, 18, 15, 0, 32'h7FF, 1'b1);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < num_rows; i++) begin
      send_row(i);
      if (!rows[i].burst) begin
        gap[1] = take_random_bit();
        gap[0] = take_random_bit();
        if (gap != 2'd0) begin
          inst_valid = 1'b0;
        end
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
    inst_valid = 1'b0;
    // Drain, then look for stray commits
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);
    i_checker.final_checks();
    #1;
    $display("Errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #((RESET_CYCLES + 40 * NUM_ROWS) * CLK_PERIOD);
    $display("Error: timeout, the instructions did not all commit in time");
    $display("Errors: %0d value mismatches, %0d other failures", mismatches,
             other_errors + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
